// File: design/pmac_frame_pkg.sv
package pmac_frame_pkg;

    ////////////////////
    // data path widths
    ////////////////////

    // one byte per beat
    localparam int DATA_W = 8;
    // enough for a 1500 byte frame
    localparam int LEN_W = 11;
    localparam int TYPE_W = 16;
    // preemption counter width
    localparam int PCNT_W = 16;

    // min fragment size out of reset
    localparam int DEF_MIN_FRAG = 46;

    ////////////////////
    // controller states
    ////////////////////

    typedef enum logic [1:0] {
        // waiting for a queued frame
        TX_IDLE,
        // pop descriptor, load tracker
        TX_DESC,
        // one byte per cycle
        TX_SEND,
        // cut by the eMAC, wait to resume
        TX_HOLD
    } tx_state_e;

endpackage

// File: design/pmac_code_pkg.sv
package pmac_code_pkg;

    // smd and fragment count codes are one byte
    localparam int CODE_W = 8;

    // frame sequence, rotates once per frame
    typedef enum logic [1:0] {
        SEQ_0,
        SEQ_1,
        SEQ_2,
        SEQ_3
    } smd_seq_e;

    // continuation count, wraps after FRAG_3
    typedef enum logic [1:0] {
        FRAG_0,
        FRAG_1,
        FRAG_2,
        FRAG_3
    } frag_cnt_e;

    ////////////////////
    // code tables
    ////////////////////

    // indexed by the enums above, entry 0 sits in the low byte
    localparam logic [3:0][CODE_W-1:0] SMD_S_CODES = {8'hb3, 8'h7f, 8'h4c, 8'he6};
    localparam logic [3:0][CODE_W-1:0] SMD_C_CODES = {8'h2a, 8'h9e, 8'h52, 8'h61};
    localparam logic [3:0][CODE_W-1:0] FRAG_CODES  = {8'hb3, 8'h7f, 8'h4c, 8'he6};

endpackage

// File: design/pmac_store_if.sv
`timescale 1ns/1ps

interface pmac_store_if;
    import pmac_frame_pkg::*;

    // head of the descriptor queue
    logic              desc_valid;
    logic [LEN_W-1:0]  desc_len;
    logic [TYPE_W-1:0] desc_type;
    // one cycle pulse, drops the head
    logic              desc_pop;
    // byte read, data one cycle after rd_en
    logic              rd_en;
    logic [DATA_W-1:0] rd_data;

    modport store (
        output desc_valid,
        output desc_len,
        output desc_type,
        input  desc_pop,
        input  rd_en,
        output rd_data
    );

    modport ctrl (
        input  desc_valid,
        input  desc_len,
        input  desc_type,
        output desc_pop,
        output rd_en,
        input  rd_data
    );

endinterface

// File: design/pmac_frag_if.sv
`timescale 1ns/1ps

interface pmac_frag_if;
    import pmac_frame_pkg::*;
    import pmac_code_pkg::*;

    // frame start with its length
    logic              frame_start;
    logic [LEN_W-1:0]  frame_len;
    // high for every byte read
    logic              beat;
    logic              preempt_ok;
    // continuation start
    logic              resume;
    // last byte of the frame is being read
    logic              frame_done;
    // codes for the next fragment
    logic [CODE_W-1:0] smd_code;
    logic [CODE_W-1:0] frag_code;
    logic              is_cont;

    modport tracker (
        input  frame_start,
        input  frame_len,
        input  beat,
        output preempt_ok,
        input  resume,
        output frame_done,
        output smd_code,
        output frag_code,
        output is_cont
    );

    modport ctrl (
        output frame_start,
        output frame_len,
        output beat,
        input  preempt_ok,
        output resume,
        input  frame_done,
        input  smd_code,
        input  frag_code,
        input  is_cont
    );

endinterface

// File: design/pmac_frame_store.sv
`timescale 1ns/1ps

module pmac_frame_store #(
    parameter int BUF_DEPTH  = 512,
    parameter int DESC_DEPTH = 8,
    parameter int MAX_FRAME  = 256
) (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  logic [pmac_frame_pkg::DATA_W-1:0] i_data,
    input  logic                              i_valid,
    input  logic                              i_last,
    input  logic [pmac_frame_pkg::LEN_W-1:0]  i_len,
    input  logic [pmac_frame_pkg::TYPE_W-1:0] i_type,
    output logic                              o_ready,
    pmac_store_if.store                       st
);
    import pmac_frame_pkg::*;

    localparam int ADDR_W = $clog2(BUF_DEPTH);
    localparam int QPTR_W = $clog2(DESC_DEPTH);
    localparam int OCC_W  = ADDR_W + 1;
    // room left for one more full frame
    localparam logic [OCC_W-1:0] READY_TH = OCC_W'(BUF_DEPTH - MAX_FRAME);

    logic [DATA_W-1:0] mem [BUF_DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [OCC_W-1:0]  occ;
    logic [DATA_W-1:0] rd_data_q;

    logic [LEN_W-1:0]  q_len  [DESC_DEPTH];
    logic [TYPE_W-1:0] q_type [DESC_DEPTH];
    logic [QPTR_W-1:0] q_head;
    logic [QPTR_W-1:0] q_tail;
    logic [QPTR_W:0]   q_cnt;
    logic              sof;
    logic              push;

    ////////////////////
    // byte buffer
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // registered read port
    always_ff @(posedge i_clk) begin
        if (st.rd_en) begin
            rd_data_q <= mem[rd_ptr];
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occ    <= '0;
        end else begin
            if (i_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (st.rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // buffered byte count
            case ({i_valid, st.rd_en})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

    assign st.rd_data = rd_data_q;
    assign o_ready    = (occ <= READY_TH);

    ////////////////////
    // descriptor queue
    ////////////////////

    // length and type come with the first beat
    assign push = i_valid && sof;

    always_ff @(posedge i_clk) begin
        // queued as soon as the first byte is stored
        if (push) begin
            q_len[q_tail]  <= i_len;
            q_type[q_tail] <= i_type;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            sof    <= 1'b1;
            q_head <= '0;
            q_tail <= '0;
            q_cnt  <= '0;
        end else begin
            // last beat re-arms start of frame
            if (i_valid) begin
                sof <= i_last;
            end
            if (push) begin
                q_tail <= q_tail + 1'b1;
            end
            if (st.desc_pop) begin
                q_head <= q_head + 1'b1;
            end
            case ({push, st.desc_pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    assign st.desc_valid = (q_cnt != '0);
    assign st.desc_len   = q_len[q_head];
    assign st.desc_type  = q_type[q_head];

endmodule

// File: design/pmac_frag_tracker.sv
`timescale 1ns/1ps

module pmac_frag_tracker (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic [pmac_frame_pkg::LEN_W-1:0] i_min_frag,
    input  logic                             i_min_frag_vld,
    pmac_frag_if.tracker                     fr
);
    import pmac_frame_pkg::*;
    import pmac_code_pkg::*;

    logic [LEN_W-1:0]  min_frag;
    // bytes read in the current fragment
    logic [LEN_W-1:0]  sent_cnt;
    // bytes of the frame not yet read
    logic [LEN_W-1:0]  rem_cnt;
    logic              done;
    smd_seq_e          seq;
    frag_cnt_e         frag;
    logic              cont;
    logic [CODE_W-1:0] smd_q;
    logic [CODE_W-1:0] frag_q;

    // loadable min fragment size
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            min_frag <= LEN_W'(DEF_MIN_FRAG);
        end else if (i_min_frag_vld) begin
            min_frag <= i_min_frag;
        end
    end

    ////////////////////
    // byte accounting
    ////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            sent_cnt <= '0;
            rem_cnt  <= '0;
        end else if (fr.frame_start) begin
            sent_cnt <= '0;
            rem_cnt  <= fr.frame_len;
        end else if (fr.resume) begin
            sent_cnt <= '0;
        end else if (fr.beat) begin
            sent_cnt <= sent_cnt + 1'b1;
            rem_cnt  <= rem_cnt - 1'b1;
        end
    end

    // counts the byte read this cycle on both sides of the cut
    assign fr.preempt_ok = (sent_cnt + 1'b1 >= min_frag) && (rem_cnt > min_frag + 1'b1);
    assign done          = fr.beat && (rem_cnt == LEN_W'(1));
    assign fr.frame_done = done;

    ////////////////////
    // code selection
    ////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            seq    <= SEQ_0;
            frag   <= FRAG_0;
            cont   <= 1'b0;
            smd_q  <= SMD_S_CODES[SEQ_0];
            frag_q <= FRAG_CODES[FRAG_0];
        end else begin
            if (fr.frame_start) begin
                cont  <= 1'b0;
                frag  <= FRAG_0;
                smd_q <= SMD_S_CODES[seq];
            end else if (fr.resume) begin
                // first continuation carries FRAG_0
                cont   <= 1'b1;
                frag   <= frag_cnt_e'(frag + 2'd1);
                smd_q  <= SMD_C_CODES[seq];
                frag_q <= FRAG_CODES[frag];
            end
            // next frame uses the next sequence value
            if (done) begin
                seq <= smd_seq_e'(seq + 2'd1);
            end
        end
    end

    assign fr.smd_code  = smd_q;
    assign fr.frag_code = frag_q;
    assign fr.is_cont   = cont;

endmodule

// File: design/pmac_tx_ctrl.sv
`timescale 1ns/1ps

module pmac_tx_ctrl (
    input  logic                              i_clk,
    input  logic                              i_rst,
    input  logic                              i_emac_busy,
    input  logic                              i_emac_apply,
    input  logic                              i_rx_ready,
    pmac_store_if.ctrl                        st,
    pmac_frag_if.ctrl                         fr,
    output logic [pmac_frame_pkg::DATA_W-1:0] o_send_data,
    output logic                              o_send_valid,
    output logic                              o_send_last,
    output logic [pmac_frame_pkg::TYPE_W-1:0] o_send_type,
    output logic [pmac_code_pkg::CODE_W-1:0]  o_smd,
    output logic                              o_smd_vld,
    output logic [pmac_code_pkg::CODE_W-1:0]  o_fra,
    output logic                              o_fra_vld,
    output logic                              o_crc,
    output logic                              o_busy,
    output logic                              o_preempt_active,
    output logic [pmac_frame_pkg::PCNT_W-1:0] o_preempt_cnt
);
    import pmac_frame_pkg::*;

    tx_state_e state;
    tx_state_e state_nx;
    logic      rd_en;
    logic      cut;
    logic      frag_end;
    logic      frag_first;
    logic      link_free;

    // eMAC idle and framer ready
    assign link_free = !i_emac_busy && i_rx_ready;
    // one byte per cycle while sending
    assign rd_en     = (state == TX_SEND);
    // byte read now ends the fragment
    assign cut       = rd_en && i_emac_apply && fr.preempt_ok;
    assign frag_end  = fr.frame_done || cut;
    // strobe was idle last cycle, so this is a fragment start
    assign frag_first = rd_en && !o_send_valid;

    ////////////////////
    // state machine
    ////////////////////

    always_comb begin
        state_nx = state;
        case (state)
            TX_IDLE: begin
                if (st.desc_valid && link_free) begin
                    state_nx = TX_DESC;
                end
            end
            TX_DESC: begin
                state_nx = TX_SEND;
            end
            TX_SEND: begin
                if (fr.frame_done) begin
                    state_nx = TX_IDLE;
                end else if (cut) begin
                    state_nx = TX_HOLD;
                end
            end
            TX_HOLD: begin
                if (link_free) begin
                    state_nx = TX_SEND;
                end
            end
            default: state_nx = TX_IDLE;
        endcase
    end

    assign st.desc_pop    = (state == TX_DESC);
    assign st.rd_en       = rd_en;
    assign fr.frame_start = (state == TX_DESC);
    assign fr.frame_len   = st.desc_len;
    assign fr.beat        = rd_en;
    assign fr.resume      = (state == TX_HOLD) && link_free;

    ////////////////////
    // output stage
    ////////////////////

    // flags delayed one cycle to line up with store data
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state            <= TX_IDLE;
            o_send_valid     <= 1'b0;
            o_send_last      <= 1'b0;
            o_smd_vld        <= 1'b0;
            o_fra_vld        <= 1'b0;
            o_crc            <= 1'b0;
            o_preempt_active <= 1'b0;
            o_preempt_cnt    <= '0;
        end else begin
            state        <= state_nx;
            o_send_valid <= rd_en;
            o_send_last  <= rd_en && frag_end;
            o_smd_vld    <= frag_first;
            o_fra_vld    <= frag_first && fr.is_cont;
            // final crc only on the fragment that closes the frame
            o_crc        <= rd_en && fr.frame_done;
            if (cut) begin
                o_preempt_active <= 1'b1;
                o_preempt_cnt    <= o_preempt_cnt + 1'b1;
            end else if (fr.frame_done) begin
                o_preempt_active <= 1'b0;
            end
        end
    end

    // codes taken at the first read of each fragment
    always_ff @(posedge i_clk) begin
        if (frag_first) begin
            o_smd <= fr.smd_code;
        end
        if (frag_first && fr.is_cont) begin
            o_fra <= fr.frag_code;
        end
        if (state == TX_DESC) begin
            o_send_type <= st.desc_type;
        end
    end

    assign o_send_data = st.rd_data;
    assign o_busy      = rd_en || o_send_valid;

endmodule

// File: design/pmac_tx_top.sv
`timescale 1ns/1ps

module pmac_tx_top #(
    parameter int BUF_DEPTH  = 512,
    parameter int DESC_DEPTH = 8,
    parameter int MAX_FRAME  = 256
) (
    input  logic                              i_clk,
    input  logic                              i_rst,
    // frame input
    input  logic [pmac_frame_pkg::DATA_W-1:0] i_data,
    input  logic                              i_valid,
    input  logic                              i_last,
    input  logic [pmac_frame_pkg::LEN_W-1:0]  i_len,
    input  logic [pmac_frame_pkg::TYPE_W-1:0] i_type,
    output logic                              o_ready,
    // min fragment size load
    input  logic [pmac_frame_pkg::LEN_W-1:0]  i_min_frag,
    input  logic                              i_min_frag_vld,
    // eMAC and framer side
    input  logic                              i_emac_busy,
    input  logic                              i_emac_apply,
    input  logic                              i_rx_ready,
    // fragment stream
    output logic [pmac_frame_pkg::DATA_W-1:0] o_send_data,
    output logic                              o_send_valid,
    output logic                              o_send_last,
    output logic [pmac_frame_pkg::TYPE_W-1:0] o_send_type,
    output logic [pmac_code_pkg::CODE_W-1:0]  o_smd,
    output logic                              o_smd_vld,
    output logic [pmac_code_pkg::CODE_W-1:0]  o_fra,
    output logic                              o_fra_vld,
    output logic                              o_crc,
    // status
    output logic                              o_busy,
    output logic                              o_preempt_active,
    output logic [pmac_frame_pkg::PCNT_W-1:0] o_preempt_cnt
);

    pmac_store_if st_if ();
    pmac_frag_if  fr_if ();

    // byte buffer and descriptor queue
    pmac_frame_store #(
        .BUF_DEPTH  (BUF_DEPTH),
        .DESC_DEPTH (DESC_DEPTH),
        .MAX_FRAME  (MAX_FRAME)
    ) u_store (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_data  (i_data),
        .i_valid (i_valid),
        .i_last  (i_last),
        .i_len   (i_len),
        .i_type  (i_type),
        .o_ready (o_ready),
        .st      (st_if.store)
    );

    // byte counts, preemption rule, smd and fragment codes
    pmac_frag_tracker u_tracker (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_min_frag     (i_min_frag),
        .i_min_frag_vld (i_min_frag_vld),
        .fr             (fr_if.tracker)
    );

    pmac_tx_ctrl u_ctrl (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_emac_busy      (i_emac_busy),
        .i_emac_apply     (i_emac_apply),
        .i_rx_ready       (i_rx_ready),
        .st               (st_if.ctrl),
        .fr               (fr_if.ctrl),
        .o_send_data      (o_send_data),
        .o_send_valid     (o_send_valid),
        .o_send_last      (o_send_last),
        .o_send_type      (o_send_type),
        .o_smd            (o_smd),
        .o_smd_vld        (o_smd_vld),
        .o_fra            (o_fra),
        .o_fra_vld        (o_fra_vld),
        .o_crc            (o_crc),
        .o_busy           (o_busy),
        .o_preempt_active (o_preempt_active),
        .o_preempt_cnt    (o_preempt_cnt)
    );

endmodule

// File: verif/pmac_tx_tb.sv
`timescale 1ns/1ps

module pmac_tx_tb;

    localparam int BUF_DEPTH  = 512;
    localparam int DESC_DEPTH = 8;
    localparam int MAX_FRAME  = 256;
    localparam int READY_TH   = BUF_DEPTH - MAX_FRAME;
    localparam int NUM_FRAMES = 24;
    // second half of the frames runs with min fragment 60
    localparam int PHASE1     = 12;
    // framer held off at start so the store fills
    localparam int STALL_CYC  = 300;

    // code tables, entry n in byte n
    localparam logic [31:0] SMD_S_TAB = 32'hb37f4ce6;
    localparam logic [31:0] SMD_C_TAB = 32'h2a9e5261;
    localparam logic [31:0] FRAG_TAB  = 32'hb37f4ce6;

    logic        i_clk;
    logic        i_rst;
    logic [7:0]  i_data;
    logic        i_valid;
    logic        i_last;
    logic [10:0] i_len;
    logic [15:0] i_type;
    logic        o_ready;
    logic [10:0] i_min_frag;
    logic        i_min_frag_vld;
    logic        i_emac_busy;
    logic        i_emac_apply;
    logic        i_rx_ready;
    logic [7:0]  o_send_data;
    logic        o_send_valid;
    logic        o_send_last;
    logic [15:0] o_send_type;
    logic [7:0]  o_smd;
    logic        o_smd_vld;
    logic [7:0]  o_fra;
    logic        o_fra_vld;
    logic        o_crc;
    logic        o_busy;
    logic        o_preempt_active;
    logic [15:0] o_preempt_cnt;

    ////////////////////
    // reference model state
    ////////////////////

    int          seed;
    int          link_seed;
    logic [7:0]  exp_bytes [$];
    int          exp_lens [$];
    logic [15:0] exp_types [$];
    int          len_tab [NUM_FRAMES];
    int          total_bytes;
    int          cycle_limit;
    int          cycle_cnt;
    int          cur_min;
    // sequence and fragment count expected next
    int          exp_seq;
    int          exp_frag;
    int          frag_len;
    int          frame_rem;
    bit          in_frag;
    bit          cont_pend;
    bit          cut_in_frame;
    int          exp_cuts;
    int          frames_sent;
    int          frames_done;
    int          wr_cnt;
    int          rd_cnt;
    bit          apply_d;
    // eMAC idle and framer ready, 1 to 3 cycles back
    bit          link_d1;
    bit          link_d2;
    bit          link_d3;
    bit          ready_low_seen;
    int          data_err;
    int          code_err;
    int          ctrl_err;
    int          apply_left;
    int          busy_left;

    pmac_tx_top #(
        .BUF_DEPTH  (BUF_DEPTH),
        .DESC_DEPTH (DESC_DEPTH),
        .MAX_FRAME  (MAX_FRAME)
    ) i_dut (.*);

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    task automatic flag_error(input int kind, input string msg);
        case (kind)
            0:       data_err++;
            1:       code_err++;
            default: ctrl_err++;
        endcase
        $display("** Error @%0t: %s", $time, msg);
    endtask

    ////////////////////
    // output checking
    ////////////////////

    // one output byte against the model
    task automatic score_byte();
        logic [7:0]  exp_b;
        logic [15:0] exp_type;
        bit          rule_ok;
        bit          exp_last;
        if (!in_frag) begin
            if (!cont_pend) begin
                // new frame, S code of the current sequence
                exp_type = exp_types.size() ? exp_types.pop_front() : 16'h0;
                frame_rem = exp_lens.size() ? exp_lens.pop_front() : 0;
                assert (frame_rem != 0) else flag_error(2, "output byte with no frame queued");
                assert (o_send_type == exp_type)
                    else flag_error(0, $sformatf("type %h, expected %h", o_send_type, exp_type));
                assert (link_d3) else flag_error(2, "frame started while the link was not free");
                assert (o_smd_vld && !o_fra_vld && o_smd == SMD_S_TAB[8*exp_seq +: 8])
                    else flag_error(1, $sformatf("start smd %h vld %b fra_vld %b, expected %h",
                        o_smd, o_smd_vld, o_fra_vld, SMD_S_TAB[8*exp_seq +: 8]));
            end else begin
                // continuation of a cut frame
                assert (link_d2) else flag_error(2, "continuation while the link was not free");
                assert (o_smd_vld && o_fra_vld && o_smd == SMD_C_TAB[8*exp_seq +: 8])
                    else flag_error(1, $sformatf("cont smd %h vld %b fra_vld %b, expected %h",
                        o_smd, o_smd_vld, o_fra_vld, SMD_C_TAB[8*exp_seq +: 8]));
                assert (o_fra == FRAG_TAB[8*exp_frag +: 8])
                    else flag_error(1, $sformatf("fra %h, expected %h",
                        o_fra, FRAG_TAB[8*exp_frag +: 8]));
                exp_frag = (exp_frag + 1) % 4;
            end
            in_frag  = 1'b1;
            frag_len = 0;
        end else begin
            assert (!o_smd_vld && !o_fra_vld) else flag_error(1, "code strobe inside a fragment");
        end
        exp_b = exp_bytes.size() ? exp_bytes.pop_front() : 8'hxx;
        assert (o_send_data === exp_b)
            else flag_error(0, $sformatf("byte %h, expected %h", o_send_data, exp_b));
        rd_cnt++;
        frag_len++;
        frame_rem--;
        // cut allowed when both sides of it reach the minimum
        rule_ok  = (frag_len >= cur_min) && (frame_rem > cur_min);
        exp_last = (frame_rem <= 0) || (apply_d && rule_ok);
        assert (o_send_last == exp_last)
            else flag_error(2, $sformatf("last %b, expected %b (frag %0d, left %0d)",
                o_send_last, exp_last, frag_len, frame_rem));
        assert (o_crc == (frame_rem <= 0))
            else flag_error(2, $sformatf("crc %b with %0d bytes left", o_crc, frame_rem));
        // fragment closed by the DUT
        if (o_send_last) begin
            assert (frag_len >= cur_min)
                else flag_error(2, $sformatf("fragment of %0d bytes", frag_len));
        end
        if (exp_last) begin
            in_frag = 1'b0;
            if (frame_rem <= 0) begin
                exp_seq      = (exp_seq + 1) % 4;
                exp_frag     = 0;
                cont_pend    = 1'b0;
                cut_in_frame = 1'b0;
                frames_done++;
            end else begin
                exp_cuts++;
                cont_pend    = 1'b1;
                cut_in_frame = 1'b1;
            end
        end
    endtask

    always @(posedge i_clk) begin
        if (!i_rst) begin
            if (o_send_valid) begin
                score_byte();
            end
            assert (o_preempt_cnt == exp_cuts[15:0])
                else flag_error(2, $sformatf("preempt count %0d, expected %0d",
                    o_preempt_cnt, exp_cuts));
            assert (o_preempt_active == cut_in_frame)
                else flag_error(2, $sformatf("preempt active %b", o_preempt_active));
            // buffered bytes against the ready threshold
            assert (o_ready == ((wr_cnt - rd_cnt) <= READY_TH))
                else flag_error(2, $sformatf("ready %b with %0d bytes buffered",
                    o_ready, wr_cnt - rd_cnt));
            if (!o_ready) begin
                ready_low_seen = 1'b1;
            end
            if (i_valid) begin
                wr_cnt++;
            end
        end
        apply_d = i_emac_apply;
        link_d3 = link_d2;
        link_d2 = link_d1;
        link_d1 = !i_emac_busy && i_rx_ready;
    end

    // stream shape
    assert property (@(posedge i_clk) disable iff (i_rst)
        o_send_valid && !o_send_last |=> o_send_valid)
        else flag_error(2, "gap inside a fragment");
    assert property (@(posedge i_clk) disable iff (i_rst) o_send_last |-> o_send_valid)
        else flag_error(2, "last without valid");
    assert property (@(posedge i_clk) disable iff (i_rst) o_crc |-> o_send_last)
        else flag_error(2, "crc flag off the last byte");
    assert property (@(posedge i_clk) disable iff (i_rst) o_smd_vld |-> o_send_valid)
        else flag_error(1, "smd strobe without data");
    assert property (@(posedge i_clk) disable iff (i_rst) o_fra_vld |-> o_smd_vld)
        else flag_error(1, "fra strobe without smd strobe");
    assert property (@(posedge i_clk) disable iff (i_rst) o_send_valid |-> o_busy)
        else flag_error(2, "busy low while sending");

    ////////////////////
    // eMAC and framer model
    ////////////////////

    always @(negedge i_clk) begin
        if (i_rst) begin
            i_rx_ready   = 1'b0;
            i_emac_busy  = 1'b0;
            i_emac_apply = 1'b0;
            apply_left   = 0;
            busy_left    = 0;
        end else begin
            if (cycle_cnt < STALL_CYC) begin
                i_rx_ready = 1'b0;
            end else begin
                i_rx_ready = ($unsigned($random(link_seed)) % 8) != 0;
            end
            // request window, then an express burst
            if (apply_left > 0) begin
                apply_left--;
                i_emac_apply = 1'b1;
                i_emac_busy  = 1'b0;
                if (apply_left == 0) begin
                    busy_left = 8 + $unsigned($random(link_seed)) % 32;
                end
            end else if (busy_left > 0) begin
                busy_left--;
                i_emac_apply = 1'b0;
                i_emac_busy  = 1'b1;
            end else begin
                i_emac_apply = 1'b0;
                i_emac_busy  = 1'b0;
                if ($unsigned($random(link_seed)) % 24 == 0) begin
                    apply_left = 1 + $unsigned($random(link_seed)) % 12;
                end
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: no finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////
    // frame source
    ////////////////////

    // first beat carries length and type
    task automatic send_frame(input int len);
        logic [15:0] ftype;
        int          gap;
        ftype = $random(seed);
        while (!o_ready) begin
            @(negedge i_clk);
        end
        exp_lens.push_back(len);
        exp_types.push_back(ftype);
        frames_sent++;
        for (int i = 0; i < len; i++) begin
            i_valid = 1'b1;
            i_data  = $random(seed);
            i_last  = (i == len - 1);
            i_len   = (i == 0) ? 11'(len) : 11'd0;
            i_type  = (i == 0) ? ftype : 16'h0;
            exp_bytes.push_back(i_data);
            @(negedge i_clk);
        end
        i_valid = 1'b0;
        i_last  = 1'b0;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(negedge i_clk);
    endtask

    task automatic wait_drain();
        while (frames_done < frames_sent) begin
            @(negedge i_clk);
        end
    endtask

    initial begin
        i_rst          = 1'b1;
        i_data         = '0;
        i_valid        = 1'b0;
        i_last         = 1'b0;
        i_len          = '0;
        i_type         = '0;
        i_min_frag     = '0;
        i_min_frag_vld = 1'b0;
        i_emac_busy    = 1'b0;
        i_emac_apply   = 1'b0;
        i_rx_ready     = 1'b0;
        cur_min        = 46;
        seed           = 18055;
        link_seed      = $random(seed);
        total_bytes    = 0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            len_tab[f] = 60 + $unsigned($random(seed)) % 141;
            total_bytes += len_tab[f];
        end
        cycle_limit = 40 * total_bytes + 2000;

        repeat (8) @(negedge i_clk);
        assert (!o_send_valid && !o_send_last && !o_smd_vld && !o_fra_vld && !o_busy
                && !o_preempt_active && o_ready && o_preempt_cnt == 0)
            else flag_error(2, "control outputs active in reset");
        i_rst = 1'b0;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (f == PHASE1) begin
                // reload the minimum while idle
                wait_drain();
                i_min_frag     = 11'd60;
                i_min_frag_vld = 1'b1;
                cur_min        = 60;
                @(negedge i_clk);
                i_min_frag_vld = 1'b0;
            end
            send_frame(len_tab[f]);
        end
        wait_drain();
        repeat (4) @(negedge i_clk);

        if (exp_cuts == 0) begin
            $display("no preemption took place during the run");
            ctrl_err++;
        end
        if (!ready_low_seen) begin
            $display("o_ready never fell, back-pressure was not reached");
            ctrl_err++;
        end
        $display("errors: data %0d, codes %0d, control %0d (frames %0d, cuts %0d)",
            data_err, code_err, ctrl_err, frames_done, exp_cuts);
        if (data_err + code_err + ctrl_err == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: project.f
design/pmac_frame_pkg.sv
design/pmac_code_pkg.sv
design/pmac_store_if.sv
design/pmac_frag_if.sv
design/pmac_frame_store.sv
design/pmac_frag_tracker.sv
design/pmac_tx_ctrl.sv
design/pmac_tx_top.sv
verif/pmac_tx_tb.sv
